// ==== src/ex_branch_pkg.sv ====
`default_nettype none

package ex_branch_pkg;

    // Data and address width of the core
    localparam int xlen = 32;

    // Instruction class codes as produced by the decoder
    localparam int ir_type_w = 4;
    localparam logic [ir_type_w-1:0] ir_alu    = 4'd0;
    localparam logic [ir_type_w-1:0] ir_load   = 4'd1;
    localparam logic [ir_type_w-1:0] ir_store  = 4'd2;
    localparam logic [ir_type_w-1:0] ir_branch = 4'd3;
    localparam logic [ir_type_w-1:0] ir_jal    = 4'd4;
    localparam logic [ir_type_w-1:0] ir_jalr   = 4'd5;

    // Conditional branch encodings of funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Predictor geometry, indexed by pc[5:2]
    localparam int bp_entries = 16;
    localparam int bp_idx_w   = 4;
    // Counters come out of reset as weakly not taken
    localparam logic [1:0] bp_ctr_init = 2'b01;

    // One instruction word seen through the B, J and I immediate layouts
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } instr_u;

endpackage

`default_nettype wire

// ==== src/ex_stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_stage_reg
    import ex_branch_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // Decoded instruction from ID
    input  wire logic                 id_valid,
    input  wire logic [ir_type_w-1:0] id_ir_type,
    input  wire logic [xlen-1:0]      id_instr,
    input  wire logic [xlen-1:0]      id_pc,
    input  wire logic [xlen-1:0]      id_rs1,
    input  wire logic [xlen-1:0]      id_rs2,
    input  wire logic                 id_pred_taken,
    input  wire logic [xlen-1:0]      id_pred_addr,
    // Redirect from EX drops the instruction fetched down the wrong path
    input  wire logic                 kill,
    // Instruction held in EX
    output logic                      ex_valid,
    output logic [ir_type_w-1:0]      ex_ir_type,
    output instr_u                    ex_instr,
    output logic [xlen-1:0]           ex_pc,
    output logic [xlen-1:0]           ex_rs1,
    output logic [xlen-1:0]           ex_rs2,
    output logic                      ex_pred_taken,
    output logic [xlen-1:0]           ex_pred_addr
);

    // The valid bit is the only control state of the stage
    // An instruction sampled while a redirect is pending was on the wrong path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid && !kill;
        end
    end

    // Payload follows ID every cycle since the stage never stalls
    // Whatever is loaded under a low valid bit is simply ignored downstream
    always_ff @(posedge clk) begin
        ex_ir_type    <= id_ir_type;
        ex_instr      <= id_instr;
        ex_pc         <= id_pc;
        ex_rs1        <= id_rs1;
        ex_rs2        <= id_rs2;
        ex_pred_taken <= id_pred_taken;
        ex_pred_addr  <= id_pred_addr;
    end

endmodule

`default_nettype wire

// ==== src/branch_compare.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_compare
    import ex_branch_pkg::*;
(
    input  wire logic [ir_type_w-1:0] ex_ir_type,
    input  wire instr_u               ex_instr,
    input  wire logic [xlen-1:0]      ex_rs1,
    input  wire logic [xlen-1:0]      ex_rs2,
    output logic                      taken
);

    logic       cond;
    logic [2:0] funct3;

    // The condition field of a conditional branch is read through the B view
    assign funct3 = ex_instr.b_fmt.funct3;

    // Evaluate the conditional branch condition on the two register operands
    always_comb begin
        case (funct3)
            f3_beq:  cond = (ex_rs1 == ex_rs2);
            f3_bne:  cond = (ex_rs1 != ex_rs2);
            f3_blt:  cond = ($signed(ex_rs1) < $signed(ex_rs2));
            f3_bge:  cond = ($signed(ex_rs1) >= $signed(ex_rs2));
            f3_bltu: cond = (ex_rs1 < ex_rs2);
            f3_bgeu: cond = (ex_rs1 >= ex_rs2);
            // Reserved encodings 010 and 011 never branch
            default: cond = 1'b0;
        endcase
    end

    // Unconditional jumps are always taken, everything else never is
    always_comb begin
        case (ex_ir_type)
            ir_branch: taken = cond;
            ir_jal:    taken = 1'b1;
            ir_jalr:   taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/target_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

module target_calc
    import ex_branch_pkg::*;
(
    input  wire logic [ir_type_w-1:0] ex_ir_type,
    input  wire instr_u               ex_instr,
    input  wire logic [xlen-1:0]      ex_pc,
    input  wire logic [xlen-1:0]      ex_rs1,
    output logic [xlen-1:0]           target,
    output logic [xlen-1:0]           pc4
);

    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] jalr_sum;

    // B immediate is scattered over the word and always even
    assign imm_b = {{19{ex_instr.b_fmt.imm12}}, ex_instr.b_fmt.imm12, ex_instr.b_fmt.imm11,
                    ex_instr.b_fmt.imm10_5, ex_instr.b_fmt.imm4_1, 1'b0};

    // J immediate covers +-1 MiB, also even
    assign imm_j = {{11{ex_instr.j_fmt.imm20}}, ex_instr.j_fmt.imm20,
                    ex_instr.j_fmt.imm19_12, ex_instr.j_fmt.imm11,
                    ex_instr.j_fmt.imm10_1, 1'b0};

    // I immediate is a plain 12-bit signed offset
    assign imm_i = {{20{ex_instr.i_fmt.imm11_0[11]}}, ex_instr.i_fmt.imm11_0};

    // JALR adds to a register, so the low bit is forced to zero afterwards
    assign jalr_sum = ex_rs1 + imm_i;

    always_comb begin
        case (ex_ir_type)
            ir_jal:  target = ex_pc + imm_j;
            ir_jalr: target = {jalr_sum[xlen-1:1], 1'b0};
            // BRANCH uses the B offset; other types take the same path but ignore it
            default: target = ex_pc + imm_b;
        endcase
    end

    // Fall-through address for a not-taken branch
    assign pc4 = ex_pc + 32'd4;

endmodule

`default_nettype wire

// ==== src/ex_jump_handler.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_jump_handler
    import ex_branch_pkg::*;
(
    input  wire logic                 ex_valid,
    input  wire logic [ir_type_w-1:0] ex_ir_type,
    // Resolved direction and addresses
    input  wire logic                 taken,
    input  wire logic [xlen-1:0]      target,
    input  wire logic [xlen-1:0]      pc4,
    // What fetch guessed for this instruction
    input  wire logic                 ex_pred_taken,
    input  wire logic [xlen-1:0]      ex_pred_addr,
    input  wire logic                 flush_from_id,
    output logic                      jump,
    output logic [xlen-1:0]           jump_addr,
    output logic                      upd_en
);

    logic is_ctrl;
    logic live;
    logic dir_wrong;
    logic addr_wrong;

    assign is_ctrl = (ex_ir_type == ir_branch) || (ex_ir_type == ir_jal) ||
                     (ex_ir_type == ir_jalr);

    // A flushed or empty slot must neither redirect nor train
    assign live = ex_valid && !flush_from_id;

    assign dir_wrong = (ex_pred_taken != taken);

    // The table is untagged, so a correctly guessed direction may still carry
    // the target of another PC that maps to the same entry
    // A not-taken guess fetched PC+4 and its address needs no check
    assign addr_wrong = ex_pred_taken && (ex_pred_addr != target);

    always_comb begin
        if (!live) begin
            jump = 1'b0;
        end else if (is_ctrl) begin
            jump = dir_wrong || addr_wrong;
        end else begin
            // Non-control types carry the comparator result as is
            jump = taken;
        end
    end

    // On a wrong taken guess the pipeline went to the target, so go back to PC+4
    assign jump_addr = taken ? target : pc4;

    // Only resolved control instructions train the predictor
    assign upd_en = live && is_ctrl;

endmodule

`default_nettype wire

// ==== src/branch_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor
    import ex_branch_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    // Lookup port used by fetch
    input  wire logic [xlen-1:0] fetch_pc,
    // Training port from EX
    input  wire logic            upd_en,
    input  wire logic [xlen-1:0] upd_pc,
    input  wire logic            upd_taken,
    input  wire logic [xlen-1:0] upd_target,
    output logic                 pred_taken,
    output logic [xlen-1:0]      pred_target
);

    logic [1:0]          ctr_q [bp_entries];
    logic [xlen-1:0]     tgt_q [bp_entries];

    logic [bp_idx_w-1:0] rd_idx;
    logic [bp_idx_w-1:0] wr_idx;
    logic [1:0]          ctr_cur;
    logic [1:0]          ctr_next;

    // Word-aligned PCs, so bits 1:0 carry no information
    assign rd_idx = fetch_pc[bp_idx_w+1:2];
    assign wr_idx = upd_pc[bp_idx_w+1:2];

    // Lookup is a plain read, fetch sees it in the same cycle
    assign pred_taken  = ctr_q[rd_idx][1];
    assign pred_target = tgt_q[rd_idx];

    assign ctr_cur = ctr_q[wr_idx];

    // Two-bit saturating counter, upper half means predict taken
    always_comb begin
        ctr_next = ctr_cur;
        if (upd_taken) begin
            if (ctr_cur != 2'b11) begin
                ctr_next = ctr_cur + 2'b01;
            end
        end else begin
            if (ctr_cur != 2'b00) begin
                ctr_next = ctr_cur - 2'b01;
            end
        end
    end

    // Counters restart weakly not taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < bp_entries; i++) begin
                ctr_q[i] <= bp_ctr_init;
            end
        end else if (upd_en) begin
            ctr_q[wr_idx] <= ctr_next;
        end
    end

    // A not-taken outcome says nothing about the target, so the old one is kept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < bp_entries; i++) begin
                tgt_q[i] <= '0;
            end
        end else if (upd_en && upd_taken) begin
            tgt_q[wr_idx] <= upd_target;
        end
    end

endmodule

`default_nettype wire

// ==== src/ex_branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_branch_unit
    import ex_branch_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // Decoded instruction from ID
    input  wire logic                 id_valid,
    input  wire logic [ir_type_w-1:0] id_ir_type,
    input  wire logic [xlen-1:0]      id_instr,
    input  wire logic [xlen-1:0]      id_pc,
    input  wire logic [xlen-1:0]      id_rs1,
    input  wire logic [xlen-1:0]      id_rs2,
    input  wire logic                 id_pred_taken,
    input  wire logic [xlen-1:0]      id_pred_addr,
    // Applies to the instruction now in EX
    input  wire logic                 flush_from_id,
    // Fetch lookup
    input  wire logic [xlen-1:0]      fetch_pc,
    // Redirect to fetch
    output logic                      jump,
    output logic [xlen-1:0]           jump_addr,
    output logic                      pred_taken,
    output logic [xlen-1:0]           pred_target
);

    logic                 ex_valid;
    logic [ir_type_w-1:0] ex_ir_type;
    instr_u               ex_instr;
    logic [xlen-1:0]      ex_pc;
    logic [xlen-1:0]      ex_rs1;
    logic [xlen-1:0]      ex_rs2;
    logic                 ex_pred_taken;
    logic [xlen-1:0]      ex_pred_addr;
    logic                 taken;
    logic [xlen-1:0]      target;
    logic [xlen-1:0]      pc4;
    logic                 upd_en;

    // The redirect itself kills the instruction entering EX
    ex_stage_reg ex_stage_reg_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_valid      (id_valid),
        .id_ir_type    (id_ir_type),
        .id_instr      (id_instr),
        .id_pc         (id_pc),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_pred_taken (id_pred_taken),
        .id_pred_addr  (id_pred_addr),
        .kill          (jump),
        .ex_valid      (ex_valid),
        .ex_ir_type    (ex_ir_type),
        .ex_instr      (ex_instr),
        .ex_pc         (ex_pc),
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .ex_pred_taken (ex_pred_taken),
        .ex_pred_addr  (ex_pred_addr)
    );

    branch_compare branch_compare_i (
        .ex_ir_type (ex_ir_type),
        .ex_instr   (ex_instr),
        .ex_rs1     (ex_rs1),
        .ex_rs2     (ex_rs2),
        .taken      (taken)
    );

    target_calc target_calc_i (
        .ex_ir_type (ex_ir_type),
        .ex_instr   (ex_instr),
        .ex_pc      (ex_pc),
        .ex_rs1     (ex_rs1),
        .target     (target),
        .pc4        (pc4)
    );

    ex_jump_handler ex_jump_handler_i (
        .ex_valid      (ex_valid),
        .ex_ir_type    (ex_ir_type),
        .taken         (taken),
        .target        (target),
        .pc4           (pc4),
        .ex_pred_taken (ex_pred_taken),
        .ex_pred_addr  (ex_pred_addr),
        .flush_from_id (flush_from_id),
        .jump          (jump),
        .jump_addr     (jump_addr),
        .upd_en        (upd_en)
    );

    // Training data comes straight from the EX slot and the resolvers
    branch_predictor branch_predictor_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_pc    (fetch_pc),
        .upd_en      (upd_en),
        .upd_pc      (ex_pc),
        .upd_taken   (taken),
        .upd_target  (target),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

endmodule

`default_nettype wire

// ==== verif/tb_ex_branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ex_branch_unit import ex_branch_pkg::*; ();

    logic                 clk;
    logic                 rst_n;
    logic                 id_valid;
    logic [ir_type_w-1:0] id_ir_type;
    logic [xlen-1:0]      id_instr;
    logic [xlen-1:0]      id_pc;
    logic [xlen-1:0]      id_rs1;
    logic [xlen-1:0]      id_rs2;
    logic                 id_pred_taken;
    logic [xlen-1:0]      id_pred_addr;
    logic                 flush_from_id;
    logic [xlen-1:0]      fetch_pc;
    logic                 jump;
    logic [xlen-1:0]      jump_addr;
    logic                 pred_taken;
    logic [xlen-1:0]      pred_target;

    integer seed;

    // Reference copy of the EX slot and of the predictor table
    logic                 m_valid;
    logic [ir_type_w-1:0] m_type;
    logic [xlen-1:0]      m_instr;
    logic [xlen-1:0]      m_pc;
    logic [xlen-1:0]      m_rs1;
    logic [xlen-1:0]      m_rs2;
    logic                 m_ptk;
    logic [xlen-1:0]      m_paddr;
    logic [1:0]           m_ctr [16];
    logic [xlen-1:0]      m_tgt [16];
    // Resolution of the current EX slot as the model sees it
    logic                 m_taken;
    logic [xlen-1:0]      m_target;
    logic                 m_jump;
    logic                 m_upd;
    logic [xlen-1:0]      last_pc;

    ex_branch_unit ex_branch_unit_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_valid      (id_valid),
        .id_ir_type    (id_ir_type),
        .id_instr      (id_instr),
        .id_pc         (id_pc),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_pred_taken (id_pred_taken),
        .id_pred_addr  (id_pred_addr),
        .flush_from_id (flush_from_id),
        .fetch_pc      (fetch_pc),
        .jump          (jump),
        .jump_addr     (jump_addr),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    // Direction straight from the RV32I rules, funct3 lives in bits 14:12
    function automatic logic model_taken(logic [3:0] t, logic [31:0] w, logic [31:0] a,
                                         logic [31:0] b);
        logic c;
        case (w[14:12])
            3'b000:  c = (a == b);
            3'b001:  c = (a != b);
            3'b100:  c = ($signed(a) < $signed(b));
            3'b101:  c = ($signed(a) >= $signed(b));
            3'b110:  c = (a < b);
            3'b111:  c = (a >= b);
            default: c = 1'b0;
        endcase
        if (t == ir_branch) return c;
        return (t == ir_jal) || (t == ir_jalr);
    endfunction

    // Immediates are rebuilt from raw bit positions of the instruction word
    function automatic logic [31:0] model_target(logic [3:0] t, logic [31:0] w,
                                                 logic [31:0] pc, logic [31:0] a);
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_i;
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        imm_i = {{20{w[31]}}, w[31:20]};
        if (t == ir_jal) return pc + imm_j;
        if (t == ir_jalr) return (a + imm_i) & ~32'd1;
        return pc + imm_b;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t: %s = %h, expected %h", $time, sig, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "output mismatch");
    endtask

    // Lookup is combinational, the poll only waits for the table read to settle
    task automatic check_lookup(input logic [31:0] pc, output logic ptk, output logic [31:0] ptg);
        logic [3:0] idx;
        int         polls;
        idx = pc[5:2];
        fetch_pc = pc;
        polls = 0;
        do begin
            #0.1;
            polls++;
        end while ($isunknown({pred_taken, pred_target}) && polls < 20);
        assert (!$isunknown({pred_taken, pred_target})) else begin
            $display("Predictor lookup of pc %h never gave a known value", pc);
            $display("=== FAIL ===");
            $fatal(1, "lookup timeout");
        end
        assert (pred_taken === m_ctr[idx][1])
            else report_mismatch("pred_taken", {31'd0, pred_taken}, {31'd0, m_ctr[idx][1]});
        assert (pred_target === m_tgt[idx])
            else report_mismatch("pred_target", pred_target, m_tgt[idx]);
        ptk = pred_taken;
        ptg = pred_target;
    endtask

    // Everything the DUT does at a rising edge, applied to the model
    task automatic advance_model();
        logic [3:0] idx;
        idx = m_pc[5:2];
        if (m_upd) begin
            if (m_taken) begin
                m_ctr[idx] = (m_ctr[idx] == 2'b11) ? 2'b11 : m_ctr[idx] + 2'b01;
                m_tgt[idx] = m_target;
            end else begin
                m_ctr[idx] = (m_ctr[idx] == 2'b00) ? 2'b00 : m_ctr[idx] - 2'b01;
            end
        end
        last_pc = m_pc;
        // A redirect at this edge drops the instruction coming from ID
        m_valid = id_valid && !m_jump;
        m_type = id_ir_type;
        m_instr = id_instr;
        m_pc = id_pc;
        m_rs1 = id_rs1;
        m_rs2 = id_rs2;
        m_ptk = id_pred_taken;
        m_paddr = id_pred_addr;
    endtask

    task automatic resolve_model();
        logic ctrl;
        logic live;
        ctrl = (m_type == ir_branch) || (m_type == ir_jal) || (m_type == ir_jalr);
        live = m_valid && !flush_from_id;
        m_taken = model_taken(m_type, m_instr, m_rs1, m_rs2);
        m_target = model_target(m_type, m_instr, m_pc, m_rs1);
        // Non-control types never branch, so they never redirect
        m_jump = live && ctrl && ((m_ptk != m_taken) || (m_ptk && m_paddr != m_target));
        m_upd = live && ctrl;
    endtask

    task automatic drive_instruction();
        logic [31:0] r;
        r = rand32();
        id_valid = (r[2:0] != 3'd0);
        flush_from_id = (r[5:3] == 3'd0);
        case (r[8:6])
            3'd0:    id_ir_type = ir_alu;
            3'd1:    id_ir_type = ir_load;
            3'd2:    id_ir_type = ir_store;
            3'd5:    id_ir_type = ir_jal;
            3'd6:    id_ir_type = ir_jalr;
            default: id_ir_type = ir_branch;
        endcase
        // 64 PCs over 16 entries, four of them share each index
        id_pc = 32'h0000_2000 + {24'd0, r[14:13], r[12:9], 2'b00};
        id_instr = rand32();
        id_rs1 = rand32();
        // Equal and near-equal operands make EQ and the signed edges likely
        case (r[16:15])
            2'd0:    id_rs2 = id_rs1;
            2'd1:    id_rs2 = id_rs1 + {30'd0, r[18:17]};
            2'd2:    id_rs2 = ~id_rs1;
            default: id_rs2 = rand32();
        endcase
    endtask

    initial begin
        logic        ptk;
        logic [31:0] ptg;
        logic [31:0] r;
        logic [31:0] exp_addr;
        seed = 32'he512_831d;
        rst_n = 1'b0;
        id_valid = 1'b0;
        id_ir_type = ir_alu;
        id_instr = '0;
        id_pc = '0;
        id_rs1 = '0;
        id_rs2 = '0;
        id_pred_taken = 1'b0;
        id_pred_addr = '0;
        flush_from_id = 1'b0;
        fetch_pc = '0;
        m_valid = 1'b0;
        m_type = ir_alu;
        m_instr = '0;
        m_pc = '0;
        m_rs1 = '0;
        m_rs2 = '0;
        m_ptk = 1'b0;
        m_paddr = '0;
        m_jump = 1'b0;
        m_upd = 1'b0;
        m_taken = 1'b0;
        m_target = '0;
        for (int i = 0; i < 16; i++) begin
            m_ctr[i] = bp_ctr_init;
            m_tgt[i] = '0;
        end
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;

        // Out of reset the slot is empty and every entry reads not taken with a zero target
        #1;
        assert (jump === 1'b0) else report_mismatch("jump", {31'd0, jump}, 32'd0);
        for (int i = 0; i < 16; i++) begin
            check_lookup(32'h0000_2000 + i * 4, ptk, ptg);
        end

        for (int n = 0; n < 2000; n++) begin
            @(posedge clk);
            advance_model();
            #2;
            drive_instruction();
            // The entry of the slot that left EX at this edge shows its trained state,
            // and is untouched when that slot was empty, flushed or killed
            check_lookup(last_pc, ptk, ptg);
            // Fetch's real guess half the time, a forced one otherwise
            r = rand32();
            if (r[0]) begin
                check_lookup(id_pc, ptk, ptg);
                id_pred_taken = ptk;
                id_pred_addr = ptg;
            end else begin
                id_pred_taken = r[1];
                id_pred_addr = r[2] ? model_target(id_ir_type, id_instr, id_pc, id_rs1) : rand32();
            end
            resolve_model();
            #1;
            assert (jump === m_jump) else report_mismatch("jump", {31'd0, jump}, {31'd0, m_jump});
            if (m_jump) begin
                exp_addr = m_taken ? m_target : m_pc + 32'd4;
                assert (jump_addr === exp_addr)
                    else report_mismatch("jump_addr", jump_addr, exp_addr);
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ex_branch_unit.f ====
src/ex_branch_pkg.sv
src/ex_stage_reg.sv
src/branch_compare.sv
src/target_calc.sv
src/ex_jump_handler.sv
src/branch_predictor.sv
src/ex_branch_unit.sv
verif/tb_ex_branch_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the EX branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_ex_branch_unit -f ex_branch_unit.f -o sim_ex_branch_unit

# A failing check ends the simulation with a nonzero status, the log gives the verdict
./obj_dir/sim_ex_branch_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
